// File: bench/tb_apb_tasks.svh
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// every task here starts and ends 1 ns after a rising edge.
task automatic apb_transfer(input logic write, input logic [3:0] addr,
                            input logic [31:0] data, output logic [31:0] rdata,
                            output logic [31:0] model_rdata);
  apb_req.psel = 1'b1; // setup cycle.
  apb_req.penable = 1'b0;
  apb_req.pwrite = write;
  apb_req.paddr = addr;
  apb_req.pwdata = data;
  @(posedge clk);
  #1;
  apb_req.penable = 1'b1; // access cycle.
  @(negedge clk);
  rdata = apb_rsp.prdata;
  model_rdata = expected_word(addr);
  last_slverr = apb_rsp.pslverr;
  @(posedge clk); // writes land on this edge.
  #1;
  apb_req = '0;
endtask

task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
  logic [31:0] unused_rdata;
  logic [31:0] unused_model;
  apb_transfer(1'b1, addr, data, unused_rdata, unused_model);
endtask

task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata,
                        output logic [31:0] model_rdata);
  apb_transfer(1'b0, addr, 32'h0, rdata, model_rdata);
endtask

task automatic wait_cycles(input int n);
  if (n > 0) begin
    repeat (n) @(posedge clk);
    #1;
  end
endtask

`endif

// File: bench/tb_rtc_top.sv
`default_nettype none

module tb_rtc_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int tb_ticks = 4;
  localparam int clk_period = 8;
  // the alarm minute dominates this rough cycle budget.
  localparam int test_cycles = 8 + 16 + 5 * 24 + 4 * 20 + 70 * tb_ticks + 60;
  localparam int watchdog_ns = 2 * test_cycles * clk_period;

  logic clk = 1'b0;
  logic reset;
  rtc_apb_pkg::apb_req_t apb_req;
  rtc_apb_pkg::apb_rsp_t apb_rsp;
  logic alarm;

  int errors = 0;
  int prop_errors = 0;
  int checks = 0;
  logic last_slverr;
  logic access;
  logic exp_slverr;
  logic wr_cycle;

  rtc_time_pkg::bcd_time_t m_time; // reference model state.
  rtc_time_pkg::bcd_date_t m_date;
  int m_presc;
  logic m_alarm_on;
  int m_alarm_min;
  logic m_alarm;

  always #(clk_period / 2) clk = ~clk;

  rtc_top #(.ticks_per_second(tb_ticks)) i_dut (
    .clk     (clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .alarm   (alarm)
  );

  function automatic int to_secs(input rtc_time_pkg::bcd_time_t t);
    return (10 * int'(t.hour_tens) + int'(t.hour_units)) * 3600 +
           (10 * int'(t.min_tens) + int'(t.min_units)) * 60 +
           10 * int'(t.sec_tens) + int'(t.sec_units);
  endfunction

  function automatic rtc_time_pkg::bcd_time_t from_secs(input int s);
    rtc_time_pkg::bcd_time_t t;
    t.hour_tens = 2'((s / 3600) / 10);
    t.hour_units = 4'((s / 3600) % 10);
    t.min_tens = 3'(((s / 60) % 60) / 10);
    t.min_units = 4'((s / 60) % 10);
    t.sec_tens = 3'((s % 60) / 10);
    t.sec_units = 4'(s % 10);
    return t;
  endfunction

  function automatic rtc_time_pkg::bcd_date_t make_date(input int day, input int month);
    rtc_time_pkg::bcd_date_t d;
    d.month = 4'(month);
    d.day_tens = 2'(day / 10);
    d.day_units = 4'(day % 10);
    return d;
  endfunction

  function automatic rtc_time_pkg::bcd_date_t next_date(input rtc_time_pkg::bcd_date_t d);
    int len [12] = '{31, 28, 31, 30, 31, 30, 31, 31, 30, 31, 30, 31};
    int day;
    int month;
    day = 10 * int'(d.day_tens) + int'(d.day_units);
    month = int'(d.month);
    if (day == len[month - 1]) begin
      return make_date(1, (month == 12) ? 1 : month + 1);
    end
    return make_date(day + 1, month);
  endfunction

  function automatic logic [31:0] time_word(input int h, input int m, input int s);
    return {12'b0, from_secs(h * 3600 + m * 60 + s)};
  endfunction

  function automatic logic [31:0] date_word(input int day, input int month);
    return {22'b0, make_date(day, month)};
  endfunction

  function automatic logic [31:0] alarm_word(input logic en, input int h, input int m);
    return {11'b0, en, from_secs(h * 3600 + m * 60)};
  endfunction

  function automatic logic [31:0] expected_word(input logic [3:0] addr);
    logic [31:0] w;
    w = '0;
    case (addr)
      rtc_apb_pkg::addr_time: w[19:0] = m_time;
      rtc_apb_pkg::addr_date: w[9:0] = m_date;
      rtc_apb_pkg::addr_alarm: w = alarm_word(m_alarm_on, m_alarm_min / 60, m_alarm_min % 60);
      rtc_apb_pkg::addr_status: w[0] = m_alarm;
      default: w = '0;
    endcase
    return w;
  endfunction

  `include "tb_apb_tasks.svh"

  assign access = apb_req.psel && apb_req.penable;
  assign wr_cycle = access && apb_req.pwrite;
  // only time, date and alarm accesses and status reads are legal.
  assign exp_slverr = access && !(apb_req.paddr inside {rtc_apb_pkg::addr_time,
      rtc_apb_pkg::addr_date, rtc_apb_pkg::addr_alarm} ||
      (!apb_req.pwrite && apb_req.paddr == rtc_apb_pkg::addr_status));

  // a time load restarts the model second at its write edge.
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      m_time <= '0;
      m_date <= make_date(1, 1);
      m_presc <= 0;
      m_alarm_on <= 1'b0;
      m_alarm_min <= 0;
      m_alarm <= 1'b0;
    end else begin
      m_alarm <= m_alarm_on && (to_secs(m_time) / 60 == m_alarm_min);
      if (wr_cycle && apb_req.paddr == rtc_apb_pkg::addr_time) begin
        m_time <= rtc_time_pkg::bcd_time_t'(apb_req.pwdata[19:0]);
        m_presc <= 0;
      end else if (m_presc == tb_ticks - 1) begin
        m_presc <= 0;
        m_time <= from_secs((to_secs(m_time) + 1) % 86400);
        if (to_secs(m_time) == 86399) begin
          m_date <= next_date(m_date);
        end
      end else begin
        m_presc <= m_presc + 1;
      end
      if (wr_cycle && apb_req.paddr == rtc_apb_pkg::addr_date) begin
        m_date <= rtc_time_pkg::bcd_date_t'(apb_req.pwdata[9:0]); // load wins over carry.
      end
      if (wr_cycle && apb_req.paddr == rtc_apb_pkg::addr_alarm) begin
        m_alarm_on <= apb_req.pwdata[20];
        m_alarm_min <= to_secs(rtc_time_pkg::bcd_time_t'(apb_req.pwdata[19:0])) / 60;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) access |-> apb_rsp.pready)
    else begin
      prop_errors = prop_errors + 1;
      $display("** Error at %0t: pready low in an access cycle", $realtime);
    end

  assert property (@(posedge clk) disable iff (reset) apb_rsp.pslverr == exp_slverr)
    else begin
      prop_errors = prop_errors + 1;
      $display("** Error at %0t: pslverr is %b, expected %b", $realtime,
               apb_rsp.pslverr, exp_slverr);
    end

  assert property (@(posedge clk) disable iff (reset) alarm == m_alarm)
    else begin
      prop_errors = prop_errors + 1;
      $display("** Error at %0t: alarm is %b, expected %b", $realtime, alarm, m_alarm);
    end

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] want);
    checks = checks + 1;
    assert (got === want) else begin
      errors = errors + 1;
      $display("** Error at %0t: %s read 0x%08h, expected 0x%08h", $realtime, what, got, want);
    end
  endtask

  task automatic read_reg(input logic [3:0] addr, input string what, output logic [31:0] data);
    logic [31:0] model_data;
    apb_read(addr, data, model_data);
    check_word(what, data, model_data);
  endtask

  task automatic check_slverr(input string what);
    checks = checks + 1;
    assert (last_slverr) else begin
      errors = errors + 1;
      $display("** Error at %0t: no pslverr on %s", $realtime, what);
    end
  endtask

  task automatic check_reset_state();
    logic [31:0] data;
    read_reg(rtc_apb_pkg::addr_time, "time after reset", data);
    check_word("time after reset", data, time_word(0, 0, 0));
    read_reg(rtc_apb_pkg::addr_date, "date after reset", data);
    check_word("date after reset", data, date_word(1, 1));
    read_reg(rtc_apb_pkg::addr_alarm, "alarm after reset", data);
    check_word("alarm after reset", data, alarm_word(1'b0, 0, 0));
  endtask

  task automatic check_random_loads();
    rtc_time_pkg::bcd_time_t t;
    logic [31:0] data;
    int pos;
    int gaps [3] = '{0, 4, 9};
    for (int i = 0; i < 5; i++) begin
      t = from_secs(int'($urandom % 86400));
      apb_write(rtc_apb_pkg::addr_time, {12'b0, t});
      pos = 0;
      for (int j = 0; j < 3; j++) begin
        wait_cycles(gaps[j]);
        pos = pos + gaps[j];
        read_reg(rtc_apb_pkg::addr_time, "time after load", data);
        // the access cycle begins one edge after pos.
        check_word("time after load", data,
                   {12'b0, from_secs((to_secs(t) + (pos + 1) / tb_ticks) % 86400)});
        pos = pos + 2;
      end
    end
  endtask

  task automatic check_carry(input int h, input int m, input int s, input int day,
                             input int month, input logic [31:0] want_time,
                             input logic [31:0] want_date);
    logic [31:0] data;
    apb_write(rtc_apb_pkg::addr_date, date_word(day, month));
    apb_write(rtc_apb_pkg::addr_time, time_word(h, m, s));
    wait_cycles(2 * tb_ticks);
    read_reg(rtc_apb_pkg::addr_time, "time after carry", data);
    check_word("time after carry", data, want_time);
    read_reg(rtc_apb_pkg::addr_date, "date after carry", data);
    check_word("date after carry", data, want_date);
  endtask

  task automatic check_alarm();
    logic [31:0] data;
    apb_write(rtc_apb_pkg::addr_alarm, alarm_word(1'b1, 7, 30));
    apb_write(rtc_apb_pkg::addr_time, time_word(7, 29, 58));
    wait_cycles(2 * tb_ticks + 1); // minute starts 8 cycles after the write edge.
    read_reg(rtc_apb_pkg::addr_status, "status in alarm minute", data);
    check_word("status in alarm minute", data, 32'h1);
    wait_cycles(60 * tb_ticks);
    read_reg(rtc_apb_pkg::addr_status, "status after alarm minute", data);
    check_word("status after alarm minute", data, 32'h0);
    apb_write(rtc_apb_pkg::addr_alarm, alarm_word(1'b0, 7, 30));
    apb_write(rtc_apb_pkg::addr_time, time_word(7, 29, 58));
    wait_cycles(3 * tb_ticks);
    read_reg(rtc_apb_pkg::addr_status, "status with alarm off", data);
    check_word("status with alarm off", data, 32'h0);
  endtask

  task automatic check_bus_errors();
    logic [31:0] data;
    apb_write(4'h3, 32'hffff_ffff);
    check_slverr("write to 0x3");
    read_reg(4'h3, "read of 0x3", data);
    check_slverr("read of 0x3");
    apb_write(rtc_apb_pkg::addr_status, 32'hffff_ffff);
    check_slverr("write to status");
    read_reg(rtc_apb_pkg::addr_time, "time after bus errors", data);
    read_reg(rtc_apb_pkg::addr_date, "date after bus errors", data);
    read_reg(rtc_apb_pkg::addr_alarm, "alarm after bus errors", data);
    check_word("alarm after bus errors", data, alarm_word(1'b0, 7, 30));
  endtask

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the test sequence finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h8680));
    $timeformat(-9, 1, " ns", 10);
    reset = 1'b1;
    apb_req = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    check_reset_state();
    check_random_loads();
    check_carry(23, 59, 58, 28, 2, time_word(0, 0, 0), date_word(1, 3));
    check_carry(23, 59, 58, 30, 4, time_word(0, 0, 0), date_word(1, 5));
    check_carry(23, 59, 58, 31, 12, time_word(0, 0, 0), date_word(1, 1));
    check_carry(14, 59, 58, 15, 6, time_word(15, 0, 0), date_word(15, 6));
    check_alarm();
    check_bus_errors();
    $display("checks: %0d, check errors: %0d, property errors: %0d",
             checks, errors, prop_errors);
    if (errors == 0 && prop_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/rtc_alarm_match.sv
`default_nettype none

module rtc_alarm_match (
  input wire logic clk,
  input wire logic reset,
  input rtc_time_pkg::bcd_time_t now_time,
  input rtc_apb_pkg::alarm_cfg_t alarm_cfg,
  output logic alarm
);

  logic match;

  // matching on hours and minutes holds for the whole minute.
  assign match = alarm_cfg.enable &&
                 (now_time.hour_tens == alarm_cfg.hour_tens) &&
                 (now_time.hour_units == alarm_cfg.hour_units) &&
                 (now_time.min_tens == alarm_cfg.min_tens) &&
                 (now_time.min_units == alarm_cfg.min_units);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      alarm <= 1'b0;
    end else begin
      alarm <= match;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rtc_apb_pkg.sv
`default_nettype none

package rtc_apb_pkg;

  localparam logic [3:0] addr_time = 4'h0;
  localparam logic [3:0] addr_date = 4'h4;
  localparam logic [3:0] addr_alarm = 4'h8;
  localparam logic [3:0] addr_status = 4'hC;

  typedef struct packed {
    logic psel;
    logic penable;
    logic pwrite;
    logic [3:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
  } apb_rsp_t;

  // time and alarm words share this layout.
  typedef struct packed {
    logic [10:0] pad;
    logic enable; // alarm word only.
    rtc_time_pkg::bcd_time_t tod;
  } reg_fields_t;

  typedef union packed {
    logic [31:0] raw;
    reg_fields_t fields;
  } reg_word_u;

  typedef struct packed {
    logic enable;
    logic [1:0] hour_tens;
    logic [3:0] hour_units;
    logic [2:0] min_tens;
    logic [3:0] min_units;
  } alarm_cfg_t;

endpackage

`default_nettype wire

// File: hdl/rtc_apb_regs.sv
`default_nettype none

module rtc_apb_regs (
  input wire logic clk,
  input wire logic reset,
  input rtc_apb_pkg::apb_req_t apb_req,
  output rtc_apb_pkg::apb_rsp_t apb_rsp,
  input rtc_time_pkg::bcd_time_t now_time,
  input rtc_time_pkg::bcd_date_t now_date,
  input wire logic alarm,
  output logic load_time,
  output rtc_time_pkg::bcd_time_t load_time_value,
  output logic load_date,
  output rtc_time_pkg::bcd_date_t load_date_value,
  output rtc_apb_pkg::alarm_cfg_t alarm_cfg
);

  rtc_apb_pkg::reg_word_u wr_word;
  rtc_apb_pkg::reg_word_u rd_word;
  logic access;
  logic mapped;
  logic wr_ok;

  assign wr_word.raw = apb_req.pwdata;
  assign access = apb_req.psel && apb_req.penable;

  always_comb begin
    case (apb_req.paddr)
      rtc_apb_pkg::addr_time,
      rtc_apb_pkg::addr_date,
      rtc_apb_pkg::addr_alarm,
      rtc_apb_pkg::addr_status: mapped = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  // status is read only.
  assign wr_ok = access && apb_req.pwrite && mapped &&
                 (apb_req.paddr != rtc_apb_pkg::addr_status);

  // strobes land on the edge that ends the access cycle.
  assign load_time = wr_ok && (apb_req.paddr == rtc_apb_pkg::addr_time);
  assign load_date = wr_ok && (apb_req.paddr == rtc_apb_pkg::addr_date);
  assign load_time_value = wr_word.fields.tod;
  assign load_date_value = rtc_time_pkg::bcd_date_t'(wr_word.raw[9:0]);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      alarm_cfg <= '0;
    end else if (wr_ok && (apb_req.paddr == rtc_apb_pkg::addr_alarm)) begin
      alarm_cfg.enable <= wr_word.fields.enable;
      alarm_cfg.hour_tens <= wr_word.fields.tod.hour_tens;
      alarm_cfg.hour_units <= wr_word.fields.tod.hour_units;
      alarm_cfg.min_tens <= wr_word.fields.tod.min_tens;
      alarm_cfg.min_units <= wr_word.fields.tod.min_units; // seconds are ignored.
    end
  end

  always_comb begin
    rd_word.raw = '0;
    case (apb_req.paddr)
      rtc_apb_pkg::addr_time: begin
        rd_word.fields.tod = now_time;
      end
      rtc_apb_pkg::addr_date: begin
        rd_word.raw[9:0] = now_date;
      end
      rtc_apb_pkg::addr_alarm: begin
        rd_word.fields.enable = alarm_cfg.enable;
        rd_word.fields.tod.hour_tens = alarm_cfg.hour_tens;
        rd_word.fields.tod.hour_units = alarm_cfg.hour_units;
        rd_word.fields.tod.min_tens = alarm_cfg.min_tens;
        rd_word.fields.tod.min_units = alarm_cfg.min_units;
      end
      rtc_apb_pkg::addr_status: begin
        rd_word.raw[0] = alarm;
      end
      default: begin
        rd_word.raw = '0;
      end
    endcase
  end

  assign apb_rsp.prdata = rd_word.raw;
  assign apb_rsp.pready = 1'b1; // no wait states.
  assign apb_rsp.pslverr = access && (!mapped ||
                           (apb_req.pwrite && apb_req.paddr == rtc_apb_pkg::addr_status));

endmodule

`default_nettype wire

// File: hdl/rtc_time_counter.sv
`default_nettype none

module rtc_time_counter #(
  parameter int ticks_per_second = rtc_time_pkg::ticks_per_second
) (
  input wire logic clk,
  input wire logic reset,
  input wire logic load_time,
  input rtc_time_pkg::bcd_time_t load_time_value,
  input wire logic load_date,
  input rtc_time_pkg::bcd_date_t load_date_value,
  output rtc_time_pkg::bcd_time_t now_time,
  output rtc_time_pkg::bcd_date_t now_date
);

  localparam int pw = (ticks_per_second > 1) ? $clog2(ticks_per_second) : 1;

  logic [pw-1:0] prescale;
  logic tick;
  logic sec_units_wrap;
  logic sec_wrap;
  logic min_units_wrap;
  logic min_wrap;
  logic hour_wrap;
  logic day_carry;
  logic last_day;
  logic [4:0] day_bin;
  rtc_time_pkg::bcd_time_t next_time;
  rtc_time_pkg::bcd_date_t next_date;

  assign tick = (prescale == pw'(ticks_per_second - 1));

  // a time load restarts the second.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prescale <= '0;
    end else if (load_time || tick) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  // carry chain.
  assign sec_units_wrap = tick && (now_time.sec_units == 4'd9);
  assign sec_wrap = sec_units_wrap && (now_time.sec_tens == rtc_time_pkg::max_sec_tens);
  assign min_units_wrap = sec_wrap && (now_time.min_units == 4'd9);
  assign min_wrap = min_units_wrap && (now_time.min_tens == rtc_time_pkg::max_min_tens);
  assign hour_wrap = min_wrap && (now_time.hour_tens == rtc_time_pkg::last_hour_tens) &&
                     (now_time.hour_units == rtc_time_pkg::last_hour_units);
  assign day_carry = hour_wrap && !load_time;

  assign day_bin = 5'(now_date.day_tens) * 5'd10 + 5'(now_date.day_units);
  assign last_day = (day_bin == rtc_time_pkg::days_in_month(now_date.month));

  always_comb begin
    next_time = now_time;
    next_date = now_date;
    if (tick) begin
      next_time.sec_units = sec_units_wrap ? 4'd0 : now_time.sec_units + 4'd1;
    end
    if (sec_units_wrap) begin
      next_time.sec_tens = sec_wrap ? 3'd0 : now_time.sec_tens + 3'd1;
    end
    if (sec_wrap) begin
      next_time.min_units = min_units_wrap ? 4'd0 : now_time.min_units + 4'd1;
    end
    if (min_units_wrap) begin
      next_time.min_tens = min_wrap ? 3'd0 : now_time.min_tens + 3'd1;
    end
    if (hour_wrap) begin
      next_time.hour_tens = 2'd0;
      next_time.hour_units = 4'd0;
    end else if (min_wrap) begin
      if (now_time.hour_units == 4'd9) begin
        next_time.hour_units = 4'd0;
        next_time.hour_tens = now_time.hour_tens + 2'd1;
      end else begin
        next_time.hour_units = now_time.hour_units + 4'd1;
      end
    end
    if (day_carry) begin
      if (last_day) begin
        next_date.day_tens = 2'd0;
        next_date.day_units = 4'd1;
        next_date.month = (now_date.month == 4'd12) ? 4'd1 : now_date.month + 4'd1;
      end else if (now_date.day_units == 4'd9) begin
        next_date.day_units = 4'd0;
        next_date.day_tens = now_date.day_tens + 2'd1;
      end else begin
        next_date.day_units = now_date.day_units + 4'd1;
      end
    end
  end

  // loads win over counting.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      now_time <= '0;
      now_date <= '{month: 4'd1, day_tens: 2'd0, day_units: 4'd1};
    end else begin
      now_time <= load_time ? load_time_value : next_time;
      now_date <= load_date ? load_date_value : next_date;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rtc_time_pkg.sv
`default_nettype none

package rtc_time_pkg;

  // clk cycles per second from a 32.768 kHz crystal.
  localparam int ticks_per_second = 32768;

  localparam logic [2:0] max_sec_tens = 3'd5;
  localparam logic [2:0] max_min_tens = 3'd5;
  localparam logic [1:0] last_hour_tens = 2'd2;
  localparam logic [3:0] last_hour_units = 4'd3;

  // 24-hour time of day in bcd.
  typedef struct packed {
    logic [1:0] hour_tens;
    logic [3:0] hour_units;
    logic [2:0] min_tens;
    logic [3:0] min_units;
    logic [2:0] sec_tens;
    logic [3:0] sec_units;
  } bcd_time_t;

  // binary month and bcd day.
  typedef struct packed {
    logic [3:0] month;
    logic [1:0] day_tens;
    logic [3:0] day_units;
  } bcd_date_t;

  // february always has 28 days as there are no leap years.
  function automatic logic [4:0] days_in_month(input logic [3:0] month);
    logic [4:0] days;
    case (month)
      4'd2: begin
        days = 5'd28;
      end
      4'd4, 4'd6, 4'd9, 4'd11: begin
        days = 5'd30;
      end
      default: begin
        days = 5'd31;
      end
    endcase
    return days;
  endfunction

endpackage

`default_nettype wire

// File: hdl/rtc_top.sv
`default_nettype none

module rtc_top #(
  parameter int ticks_per_second = rtc_time_pkg::ticks_per_second
) (
  input wire logic clk,
  input wire logic reset,
  input rtc_apb_pkg::apb_req_t apb_req,
  output rtc_apb_pkg::apb_rsp_t apb_rsp,
  output logic alarm
);

  logic load_time;
  rtc_time_pkg::bcd_time_t load_time_value;
  logic load_date;
  rtc_time_pkg::bcd_date_t load_date_value;
  rtc_time_pkg::bcd_time_t now_time;
  rtc_time_pkg::bcd_date_t now_date;
  rtc_apb_pkg::alarm_cfg_t alarm_cfg;

  rtc_apb_regs i_regs (
    .clk             (clk),
    .reset           (reset),
    .apb_req         (apb_req),
    .apb_rsp         (apb_rsp),
    .now_time        (now_time),
    .now_date        (now_date),
    .alarm           (alarm),
    .load_time       (load_time),
    .load_time_value (load_time_value),
    .load_date       (load_date),
    .load_date_value (load_date_value),
    .alarm_cfg       (alarm_cfg)
  );

  rtc_time_counter #(
    .ticks_per_second (ticks_per_second)
  ) i_counter (
    .clk             (clk),
    .reset           (reset),
    .load_time       (load_time),
    .load_time_value (load_time_value),
    .load_date       (load_date),
    .load_date_value (load_date_value),
    .now_time        (now_time),
    .now_date        (now_date)
  );

  rtc_alarm_match i_alarm (
    .clk       (clk),
    .reset     (reset),
    .now_time  (now_time),
    .alarm_cfg (alarm_cfg),
    .alarm     (alarm)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the rtc testbench with Verilator, then check the log.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_rtc_top -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rtc_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1

// File: sources.f
hdl/rtc_time_pkg.sv
hdl/rtc_apb_pkg.sv
hdl/rtc_alarm_match.sv
hdl/rtc_time_counter.sv
hdl/rtc_apb_regs.sv
hdl/rtc_top.sv
+incdir+bench
bench/tb_rtc_top.sv
